//--- Makefile
VERILATOR ?= verilator
TOP       ?= enigma_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) sim/enigma_tb_model.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
+incdir+sim
logic/enigma_sym_pkg.sv
logic/enigma_ctrl_pkg.sv
logic/enigma_ctrl.sv
logic/rotor_table.sv
logic/return_path.sv
logic/enigma_top.sv
sim/enigma_tb.sv

//--- logic/enigma_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module enigma_ctrl (
    input  wire                          clk,
    input  wire                          srstn,
    input  wire                          load_i,
    input  wire                          encrypt_i,
    input  wire enigma_sym_pkg::symbol_t code_i,
    output enigma_ctrl_pkg::stage_t      stage_o
);

    enigma_ctrl_pkg::ctrl_state_e state_q;
    enigma_ctrl_pkg::ctrl_state_e state_d;
    enigma_ctrl_pkg::stage_t      stage_d;
    logic                         load_ok;
    logic                         crypt_ok;

    // wiring is taken only up to the first drop of load_i
    assign load_ok = (state_q == enigma_ctrl_pkg::IDLE) ||
                     (state_q == enigma_ctrl_pkg::LOAD);

    assign crypt_ok = (state_q == enigma_ctrl_pkg::READY);

    always_comb begin
        state_d = state_q;
        case (state_q)
            enigma_ctrl_pkg::IDLE: begin
                if (load_i) begin
                    state_d = enigma_ctrl_pkg::LOAD;
                end
            end
            enigma_ctrl_pkg::LOAD: begin
                if (!load_i) begin
                    state_d = enigma_ctrl_pkg::READY;
                end
            end
            enigma_ctrl_pkg::READY: begin
                // only a reset leaves this state
                state_d = enigma_ctrl_pkg::READY;
            end
            default: begin
                state_d = enigma_ctrl_pkg::IDLE;
            end
        endcase
    end

    // flags are exclusive by state
    always_comb begin
        stage_d.code  = code_i;
        stage_d.load  = load_i & load_ok;
        stage_d.crypt = encrypt_i & crypt_ok;
    end

    always_ff @(posedge clk) begin
        if (!srstn) begin
            state_q <= enigma_ctrl_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // input stage register
    always_ff @(posedge clk) begin
        if (!srstn) begin
            stage_o <= '0;
        end else begin
            stage_o <= stage_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/enigma_ctrl_pkg.sv
`default_nettype none

package enigma_ctrl_pkg;

    // load/ready sequencing
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1,
        READY = 2'd2
    } ctrl_state_e;

    // one registered input cycle
    // load and crypt are already qualified by the state
    typedef struct packed {
        enigma_sym_pkg::symbol_t code;
        logic                    load;
        logic                    crypt;
    } stage_t;

endpackage

`default_nettype wire

//--- logic/enigma_sym_pkg.sv
`default_nettype none

package enigma_sym_pkg;

    // symbol alphabet
    localparam int SYMBOL_W = 6;

    // one rotor position per symbol
    localparam int ROTOR_DEPTH = 64;

    // one 6-bit symbol code
    typedef logic [SYMBOL_W-1:0] symbol_t;

    // full rotor wiring
    // position 0 sits in the low word, position 63 in the high word
    typedef symbol_t [ROTOR_DEPTH-1:0] rotor_t;

endpackage

`default_nettype wire

//--- logic/enigma_top.sv
`timescale 1ns/1ns
`default_nettype none

module enigma_top (
    input  wire                          clk,
    input  wire                          srstn,
    input  wire                          load_i,
    input  wire                          encrypt_i,
    input  wire enigma_sym_pkg::symbol_t code_i,
    output wire enigma_sym_pkg::symbol_t code_o,
    output wire                          code_valid_o
);

    wire enigma_ctrl_pkg::stage_t stage;
    wire enigma_sym_pkg::rotor_t  rotor;
    wire enigma_sym_pkg::symbol_t fwd;

    enigma_ctrl u_ctrl (
        .clk       (clk),
        .srstn     (srstn),
        .load_i    (load_i),
        .encrypt_i (encrypt_i),
        .code_i    (code_i),
        .stage_o   (stage)
    );

    // rotor and return path both act on the same stage
    rotor_table u_rotor (
        .clk     (clk),
        .srstn   (srstn),
        .stage_i (stage),
        .rotor_o (rotor),
        .fwd_o   (fwd)
    );

    return_path u_return (
        .clk          (clk),
        .srstn        (srstn),
        .stage_i      (stage),
        .fwd_i        (fwd),
        .rotor_i      (rotor),
        .code_o       (code_o),
        .code_valid_o (code_valid_o)
    );

endmodule

`default_nettype wire

//--- logic/return_path.sv
`timescale 1ns/1ns
`default_nettype none

module return_path (
    input  wire                          clk,
    input  wire                          srstn,
    input  wire enigma_ctrl_pkg::stage_t stage_i,
    input  wire enigma_sym_pkg::symbol_t fwd_i,
    input  wire enigma_sym_pkg::rotor_t  rotor_i,
    output enigma_sym_pkg::symbol_t      code_o,
    output logic                         code_valid_o
);

    enigma_sym_pkg::symbol_t refl;
    enigma_sym_pkg::symbol_t inv;

    // reflector pairs a with 63 - a
    assign refl = enigma_sym_pkg::symbol_t'(enigma_sym_pkg::ROTOR_DEPTH - 1) - fwd_i;

    // inverse lookup over every position
    always_comb begin
        inv = '0;
        // walk downward so the lowest match is the one kept
        for (int j = enigma_sym_pkg::ROTOR_DEPTH - 1; j >= 0; j--) begin
            if (rotor_i[j] == refl) begin
                inv = enigma_sym_pkg::symbol_t'(j);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!srstn) begin
            code_valid_o <= 1'b0;
        end else begin
            code_valid_o <= stage_i.crypt;
        end
    end

    // holds the last result between symbols
    always_ff @(posedge clk) begin
        if (!srstn) begin
            code_o <= '0;
        end else if (stage_i.crypt) begin
            code_o <= inv;
        end
    end

endmodule

`default_nettype wire

//--- logic/rotor_table.sv
`timescale 1ns/1ns
`default_nettype none

module rotor_table (
    input  wire                          clk,
    input  wire                          srstn,
    input  wire enigma_ctrl_pkg::stage_t stage_i,
    output enigma_sym_pkg::rotor_t       rotor_o,
    output enigma_sym_pkg::symbol_t      fwd_o
);

    enigma_sym_pkg::rotor_t rotor_q;
    enigma_sym_pkg::rotor_t rotor_d;

    always_comb begin
        rotor_d = rotor_q;
        if (stage_i.load) begin
            // shift down with the new symbol entering at the top position
            for (int k = 0; k < enigma_sym_pkg::ROTOR_DEPTH - 1; k++) begin
                rotor_d[k] = rotor_q[k + 1];
            end
            rotor_d[enigma_sym_pkg::ROTOR_DEPTH - 1] = stage_i.code;
        end else if (stage_i.crypt) begin
            // one step per encrypted symbol with the top wrapping to 0
            for (int k = 1; k < enigma_sym_pkg::ROTOR_DEPTH; k++) begin
                rotor_d[k] = rotor_q[k - 1];
            end
            rotor_d[0] = rotor_q[enigma_sym_pkg::ROTOR_DEPTH - 1];
        end
    end

    always_ff @(posedge clk) begin
        if (!srstn) begin
            rotor_q <= '0;
        end else begin
            rotor_q <= rotor_d;
        end
    end

    assign rotor_o = rotor_q;

    // forward substitution from the table before this cycle's step
    assign fwd_o = rotor_q[stage_i.code];

endmodule

`default_nettype wire

//--- sim/enigma_tb_model.svh
`ifndef ENIGMA_TB_MODEL_SVH
`define ENIGMA_TB_MODEL_SVH

localparam int RNG_SEED  = 83332;
localparam int DEPTH     = 64;
localparam int TABLE_LEN = 64;

localparam int MODE_IDLE  = 0;
localparam int MODE_LOAD  = 1;
localparam int MODE_READY = 2;

// test ranges inside the table
localparam int T1_FIRST = 0;
localparam int T1_LAST  = 3;
localparam int T3_FIRST = 4;
localparam int T3_LAST  = 43;
localparam int T4_FIRST = 44;
localparam int T4_LAST  = 55;
localparam int T6_FIRST = 56;
localparam int T6_LAST  = 63;

// one input cycle
typedef struct packed {
    logic       load;
    logic       enc;
    logic [5:0] sym;
} stim_t;

// bit 7 load_i, bit 6 encrypt_i, bits 5:0 code_i
localparam stim_t STIM_TABLE [0:TABLE_LEN-1] = '{
    8'h45, 8'h7A, 8'h40, 8'h7F,
    8'h4C, 8'h63, 8'h57, 8'h41, 8'h6E, 8'h79, 8'h52, 8'h48,
    8'h7D, 8'h66, 8'h43, 8'h5A, 8'h71, 8'h4F, 8'h60, 8'h6B,
    8'h55, 8'h47, 8'h7E, 8'h58, 8'h6A, 8'h42, 8'h74, 8'h4D,
    8'h61, 8'h7B, 8'h50, 8'h69, 8'h46, 8'h73, 8'h5C, 8'h44,
    8'h77, 8'h65, 8'h59, 8'h4A, 8'h7C, 8'h6F, 8'h53, 8'h68,
    // gaps between encrypted symbols
    8'h6D, 8'h12, 8'h5E, 8'h07, 8'h3C, 8'h70, 8'h4B, 8'h29,
    8'h62, 8'h3F, 8'h00, 8'h56,
    // load_i raised while ready
    8'h9A, 8'hA5, 8'h83, 8'h64, 8'h5B, 8'hE1, 8'h8F, 8'h72
};

logic [5:0] perm [0:DEPTH-1];
logic [5:0] model_rotor [0:DEPTH-1];
int         model_mode;

// fisher-yates shuffle of the identity
function automatic void build_perm();
    int         j;
    logic [5:0] tmp;
    for (int i = 0; i < DEPTH; i++) begin
        perm[i] = 6'(i);
    end
    for (int i = DEPTH - 1; i > 0; i--) begin
        j = int'($urandom % unsigned'(i + 1));
        tmp = perm[i];
        perm[i] = perm[j];
        perm[j] = tmp;
    end
endfunction

function automatic void model_reset();
    for (int k = 0; k < DEPTH; k++) begin
        model_rotor[k] = 6'h00;
    end
    model_mode = MODE_IDLE;
endfunction

// new symbol enters at the top
function automatic void model_shift_in(input logic [5:0] sym);
    for (int k = 0; k < DEPTH - 1; k++) begin
        model_rotor[k] = model_rotor[k + 1];
    end
    model_rotor[DEPTH - 1] = sym;
endfunction

function automatic void model_rotate();
    logic [5:0] top;
    top = model_rotor[DEPTH - 1];
    for (int k = DEPTH - 1; k > 0; k--) begin
        model_rotor[k] = model_rotor[k - 1];
    end
    model_rotor[0] = top;
endfunction

// forward, reflect, then lowest position holding the reflected value
function automatic logic [5:0] model_encrypt(input logic [5:0] x);
    logic [5:0] target;
    logic [5:0] result;
    logic       found;
    target = 6'd63 - model_rotor[x];
    result = 6'h00;
    found = 1'b0;
    for (int j = 0; j < DEPTH; j++) begin
        if (!found && model_rotor[j] == target) begin
            result = 6'(j);
            found = 1'b1;
        end
    end
    return result;
endfunction

// advances one sampled input cycle and reports whether an output is due
function automatic logic model_cycle(input logic ld, input logic enc,
                                     input logic [5:0] sym, output logic [5:0] out);
    logic produced;
    produced = 1'b0;
    out = 6'h00;
    if (ld && model_mode != MODE_READY) begin
        model_shift_in(sym);
    end else if (enc && model_mode == MODE_READY) begin
        out = model_encrypt(sym);
        model_rotate();
        produced = 1'b1;
    end
    if (model_mode == MODE_IDLE && ld) begin
        model_mode = MODE_LOAD;
    end else if (model_mode == MODE_LOAD && !ld) begin
        model_mode = MODE_READY;
    end
    return produced;
endfunction

`endif

//--- sim/enigma_tb.sv
`timescale 1ns/1ns
`default_nettype none

module enigma_tb;

    localparam int RESET_CYCLES = 8;
    localparam int SLACK_CYCLES = 8;
    localparam int LOAD_COUNT   = 2;
    localparam int DRAIN_MAX    = 4;

    logic                    clk;
    logic                    srstn;
    logic                    load_i;
    logic                    encrypt_i;
    enigma_sym_pkg::symbol_t code_i;
    enigma_sym_pkg::symbol_t code_o;
    logic                    code_valid_o;

    // expected outputs in issue order
    logic [5:0] exp_code [$];
    int         exp_cycle [$];
    logic [5:0] plain_q [$];
    logic [5:0] out_q [$];
    logic [5:0] cipher_q [$];
    logic       recording = 1'b0;
    int         cycle = 0;
    int         errors = 0;
    int         checks = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         errors_at_start = 0;

    `include "enigma_tb_model.svh"

    localparam int CYCLE_LIMIT =
        (RESET_CYCLES + DEPTH + TABLE_LEN + SLACK_CYCLES) * LOAD_COUNT;

    enigma_top dut0 (
        .clk          (clk),
        .srstn        (srstn),
        .load_i       (load_i),
        .encrypt_i    (encrypt_i),
        .code_i       (code_i),
        .code_o       (code_o),
        .code_valid_o (code_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("ERROR: run still going after %0d cycles", cycle);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_outputs();
        logic [5:0] want;
        int         due;
        if (srstn === 1'b1) begin
            if (code_valid_o === 1'b1) begin
                if (recording) begin
                    out_q.push_back(code_o);
                end
                if (exp_code.size() == 0) begin
                    $display("ERROR: code_valid_o high at cycle %0d with nothing in flight",
                             cycle);
                    errors++;
                end else begin
                    want = exp_code.pop_front();
                    due = exp_cycle.pop_front();
                    checks++;
                    if (due != cycle) begin
                        $display("ERROR: output due at cycle %0d came at cycle %0d", due, cycle);
                        errors++;
                    end
                    if (code_o !== want) begin
                        $display("MISMATCH code_o: got 0x%02h, expected 0x%02h", code_o, want);
                        errors++;
                    end
                end
            end else if (code_valid_o !== 1'b0) begin
                $display("ERROR: code_valid_o is unknown at cycle %0d", cycle);
                errors++;
            end else if (exp_cycle.size() > 0 && exp_cycle[0] < cycle) begin
                $display("ERROR: no output for the symbol due at cycle %0d", exp_cycle[0]);
                errors++;
                void'(exp_code.pop_front());
                void'(exp_cycle.pop_front());
            end
        end
    endtask

    // check outputs and then drive new inputs on the falling edge
    task automatic tick(input logic ld, input logic enc, input logic [5:0] sym);
        logic [5:0] out;
        logic       produced;
        @(negedge clk);
        check_outputs();
        load_i = ld;
        encrypt_i = enc;
        code_i = sym;
        produced = model_cycle(ld, enc, sym, out);
        if (produced) begin
            exp_code.push_back(out);
            exp_cycle.push_back(cycle + 2);
        end
    endtask

    task automatic apply_entry(input int idx);
        stim_t e;
        e = STIM_TABLE[idx];
        tick(e.load, e.enc, e.sym);
    endtask

    task automatic reset_dut();
        srstn = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) begin
            tick(1'b0, 1'b0, 6'h00);
        end
        srstn = 1'b1;
    endtask

    // first symbol loaded ends at position 0
    task automatic load_perm();
        for (int i = 0; i < DEPTH; i++) begin
            tick(1'b1, 1'b0, perm[i]);
        end
        tick(1'b0, 1'b0, 6'h00);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_code.size() > 0 && waited < DRAIN_MAX) begin
            tick(1'b0, 1'b0, 6'h00);
            waited++;
        end
        if (exp_code.size() > 0) begin
            $display("ERROR: %0d outputs never appeared", exp_code.size());
            errors++;
            exp_code.delete();
            exp_cycle.delete();
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        srstn = 1'b0;
        load_i = 1'b0;
        encrypt_i = 1'b0;
        code_i = 6'h00;
        void'($urandom(RNG_SEED));
        build_perm();
        reset_dut();

        for (int i = T1_FIRST; i <= T1_LAST; i++) begin
            apply_entry(i);
            if (code_o !== 6'h00) begin
                $display("MISMATCH code_o: got 0x%02h, expected 0x00", code_o);
                errors++;
            end
        end
        repeat (2) begin
            tick(1'b0, 1'b0, 6'h00);
        end
        end_test("encrypt_before_load");

        load_perm();
        recording = 1'b1;
        plain_q.push_back(6'h2B);
        tick(1'b0, 1'b1, 6'h2B);
        drain();
        end_test("single_symbol");

        for (int i = T3_FIRST; i <= T3_LAST; i++) begin
            plain_q.push_back(STIM_TABLE[i].sym);
            apply_entry(i);
        end
        drain();
        recording = 1'b0;
        end_test("back_to_back");

        for (int i = T4_FIRST; i <= T4_LAST; i++) begin
            apply_entry(i);
        end
        drain();
        end_test("gaps");

        for (int i = T6_FIRST; i <= T6_LAST; i++) begin
            apply_entry(i);
        end
        drain();
        end_test("load_after_ready");

        // same wiring and start position map the ciphertext back
        cipher_q = out_q;
        out_q.delete();
        reset_dut();
        load_perm();
        recording = 1'b1;
        foreach (cipher_q[i]) begin
            tick(1'b0, 1'b1, cipher_q[i]);
        end
        drain();
        recording = 1'b0;
        if (out_q.size() != plain_q.size()) begin
            $display("ERROR: %0d symbols came back, %0d were sent", out_q.size(),
                     plain_q.size());
            errors++;
        end else begin
            foreach (out_q[i]) begin
                checks++;
                if (out_q[i] !== plain_q[i]) begin
                    $display("MISMATCH code_o: got 0x%02h, expected 0x%02h", out_q[i],
                             plain_q[i]);
                    errors++;
                end
            end
        end
        end_test("reciprocity");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
